//--- all.f
logic/frame_log_pkg.sv
logic/beat_fifo.sv
logic/frame_ingress.sv
logic/script_match.sv
logic/frame_log_writer.sv
logic/frame_log_top.sv
dv/frame_log_tb.sv

//--- Makefile
# Verilator build and run of the frame logger testbench

SRC := $(wildcard logic/*.sv dv/*.sv)

.PHONY: all run clean

all: obj_dir/Vframe_log_tb

obj_dir/Vframe_log_tb: all.f $(SRC)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module frame_log_tb -f all.f

run: obj_dir/Vframe_log_tb
	obj_dir/Vframe_log_tb | tee sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/frame_log_tb.sv
/*
	Testbench for the frame logger
	Clock, reset, frame stimulus, reference log model,
	log stream comparator and watchdog
*/

module frame_log_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int dw = 64;
	localparam logic [7:0] dir_id = 8'h41;
	localparam logic [15:0] tb_log_id = 16'hC0DE;
	localparam int hdr_beats = (frame_log_pkg::header_bits + dw - 1) / dw;

	logic clk;
	logic rst_n;
	logic [15:0] log_id;
	logic [dw-1:0] in_data;
	logic [3:0] in_bytes;
	logic in_last;
	logic in_valid;
	logic in_ready;
	logic [3:0][dw-1:0] script_pattern;
	logic [3:0][dw-1:0] script_mask;
	logic [3:0] script_enable;
	logic [dw-1:0] log_data;
	logic log_last;
	logic log_valid;
	logic log_ready;

	int seed;
	int gap_seed;
	logic bp_on;         // Random log_ready gaps
	logic [63:0] cyc;    // Tracks the DUT timestamp counter
	int sent_beats;
	int checks;
	int errors;
	int tests;

	logic [dw-1:0] cur_beats[$];
	logic [dw-1:0] exp_data[$];
	logic exp_last[$];

	frame_log_top #(.data_width(dw), .direction_id(dir_id)) dut0 (
		.clk(clk), .rst_n(rst_n), .log_id(log_id),
		.in_data(in_data), .in_bytes(in_bytes), .in_last(in_last),
		.in_valid(in_valid), .in_ready(in_ready),
		.script_pattern(script_pattern), .script_mask(script_mask),
		.script_enable(script_enable),
		.log_data(log_data), .log_last(log_last), .log_valid(log_valid),
		.log_ready(log_ready)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		if (!rst_n)
			cyc <= '0;
		else
			cyc <= cyc + 64'd1;
	end

	always @(negedge clk) begin
		if (bp_on)
			log_ready = ($random(gap_seed) & 3) != 0;  // About one stall in four
		else
			log_ready = 1'b1;
	end

	//------------------------------------------------------------
	// Reference model
	//------------------------------------------------------------
	function automatic logic [3:0] script_hits(input logic [dw-1:0] first);
		logic [3:0] m;
		m = '0;
		for (int i = 0; i < 4; i++) begin
			if (script_enable[i] &&
				(first & script_mask[i]) == (script_pattern[i] & script_mask[i]))
				m[i] = 1'b1;
		end
		return m;
	endfunction

	function automatic logic [hdr_beats*dw-1:0] header_word(input logic [15:0] nbytes,
		input logic [63:0] ts, input logic [3:0] m);
		logic [15:0] rounded;
		rounded = (nbytes + 16'd7) & 16'hFFF8;
		return {28'h0, m, nbytes, 8'd8, dir_id, ts, 16'd16 + rounded, tb_log_id,
			frame_log_pkg::log_magic};
	endfunction

	// Header beats, then the frame beats with last on the final one
	task automatic expect_frame(input int nbytes, input logic [63:0] ts);
		logic [3:0] m;
		logic [hdr_beats*dw-1:0] hdr;
		int n;
		m = script_hits(cur_beats[0]);
		n = cur_beats.size();
		if (m != 4'd0) begin
			hdr = header_word(16'(nbytes), ts, m);
			for (int i = 0; i < hdr_beats; i++) begin
				exp_data.push_back(hdr[dw*i +: dw]);
				exp_last.push_back(1'b0);
			end
			for (int i = 0; i < n; i++) begin
				exp_data.push_back(cur_beats[i]);
				exp_last.push_back(i == n - 1);
			end
		end
	endtask

	task automatic check_value(input string name, input logic [dw-1:0] got,
		input logic [dw-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error: %s is %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// Log stream comparator
	always @(posedge clk) begin
		if (rst_n && log_valid && log_ready) begin
			if (exp_data.size() == 0) begin
				errors++;
				$display("Extra log beat %h appeared with no logged frame pending", log_data);
			end else begin
				check_value("log_data", log_data, exp_data.pop_front());
				check_value("log_last", 64'(log_last), 64'(exp_last.pop_front()));
			end
		end
	end

	//------------------------------------------------------------
	// Stimulus helpers
	//------------------------------------------------------------
	task automatic send_frame(input logic [dw-1:0] first_word, input int nbytes);
		int nbeats;
		logic [63:0] ts;
		nbeats = (nbytes + 7) / 8;
		ts = '0;
		cur_beats.delete();
		for (int i = 0; i < nbeats; i++) begin
			@(negedge clk);
			in_data = (i == 0) ? first_word : {$random(seed), $random(seed)};
			in_bytes = (i == nbeats - 1) ? 4'(nbytes - 8 * i) : 4'd8;
			in_last = (i == nbeats - 1);
			in_valid = 1'b1;
			cur_beats.push_back(in_data);
			@(posedge clk);
			while (!in_ready)
				@(posedge clk);
			if (i == 0)
				ts = cyc;  // Counter value in the accepting cycle
			sent_beats++;
		end
		expect_frame(nbytes, ts);
	endtask

	task automatic wait_drain();
		@(negedge clk);
		in_valid = 1'b0;
		in_last = 1'b0;
		while (exp_data.size() != 0)
			@(posedge clk);
		repeat (30) @(negedge clk);  // Room for stray beats to show up
	endtask

	task automatic set_script(input int idx, input logic en, input logic [dw-1:0] pat,
		input logic [dw-1:0] mask);
		script_enable[idx] = en;
		script_pattern[idx] = pat;
		script_mask[idx] = mask;
	endtask

	task automatic report_test(input string name, input int err_before);
		tests++;
		if (errors == err_before)
			$display("test %0d %s: ok", tests, name);
		else
			$display("test %0d %s: %0d errors", tests, name, errors - err_before);
	endtask

	//------------------------------------------------------------
	// Test sequence
	//------------------------------------------------------------
	initial begin
		int err0;
		int sizes[6];
		logic [dw-1:0] pat;
		seed = 31970;
		gap_seed = seed + 1;
		clk = 1'b0;
		rst_n = 1'b0;
		log_id = tb_log_id;
		in_data = '0;
		in_bytes = '0;
		in_last = 1'b0;
		in_valid = 1'b0;
		script_pattern = '0;
		script_mask = '0;
		script_enable = '0;
		log_ready = 1'b0;
		bp_on = 1'b0;
		sent_beats = 0;
		checks = 0;
		errors = 0;
		tests = 0;

		err0 = errors;
		repeat (3) begin
			@(negedge clk);
			check_value("in_ready", 64'(in_ready), '0);
			check_value("log_valid", 64'(log_valid), '0);
		end
		rst_n = 1'b1;
		@(posedge clk);  // First edge out of reset
		check_value("in_ready", 64'(in_ready), '0);
		check_value("log_valid", 64'(log_valid), '0);
		report_test("reset", err0);

		err0 = errors;
		pat = 64'h0123_4567_89AB_CDEF;
		@(negedge clk);
		set_script(0, 1'b1, pat, '1);
		send_frame(pat, 40);
		wait_drain();
		report_test("matched frame", err0);

		err0 = errors;
		send_frame(pat ^ 64'h1, 24);  // Dropped
		send_frame(pat, 17);
		wait_drain();
		report_test("unmatched frame", err0);

		err0 = errors;
		set_script(0, 1'b1, 64'hA500_0000_0000_0000, 64'hFF00_0000_0000_0000);
		set_script(1, 1'b1, 64'h0000_0000_0000_1234, 64'h0000_0000_0000_FFFF);
		set_script(2, 1'b0, '0, '0);  // Would match anything if enabled
		set_script(3, 1'b1, 64'h5, 64'hF);
		send_frame(64'hA5FF_0000_0000_1234, 16);
		send_frame(64'hA500_1111_2222_0005, 9);
		send_frame(64'h3C00_0000_0000_1235, 12);
		send_frame(64'h0000_0000_0000_0000, 8);
		wait_drain();
		report_test("matching rules", err0);

		err0 = errors;
		set_script(0, 1'b1, '0, '0);
		set_script(1, 1'b0, '0, '0);
		set_script(3, 1'b0, '0, '0);
		sizes = '{1, 5, 8, 13, 63, 64};
		foreach (sizes[i])
			send_frame({$random(seed), $random(seed)}, sizes[i]);
		wait_drain();
		report_test("frame sizes", err0);

		err0 = errors;
		set_script(0, 1'b1, 64'h1, 64'h1);  // Odd first beats only
		bp_on = 1'b1;
		repeat (12)
			send_frame({$random(seed), $random(seed)}, ($random(seed) & 127) + 1);
		wait_drain();
		bp_on = 1'b0;
		report_test("back-pressure", err0);

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	// Limit grows with the beats sent so far
	initial begin : watchdog
		int waited;
		waited = 0;
		while (waited <= sent_beats * 20 + 2000) begin
			@(posedge clk);
			waited++;
		end
		$display("Timeout after %0d cycles with %0d log beats still missing",
			waited, exp_data.size());
		$display(">>> FAIL");
		$finish;
	end

endmodule

//--- logic/frame_log_top.sv
/*
	Frame logger top level
	Ingress, first-beat match, data and descriptor FIFOs, log writer
*/

module frame_log_top #(
	parameter int data_width = 64,
	parameter logic [7:0] direction_id = 8'd65,
	parameter int data_depth = 512,  // Must hold the longest frame
	parameter int desc_depth = 16
) (
	input logic clk,
	input logic rst_n,

	input logic [15:0] log_id,

	input logic [data_width-1:0] in_data,
	input logic [$clog2(data_width/8):0] in_bytes,
	input logic in_last,
	input logic in_valid,
	output logic in_ready,

	input logic [frame_log_pkg::num_scripts-1:0][data_width-1:0] script_pattern,
	input logic [frame_log_pkg::num_scripts-1:0][data_width-1:0] script_mask,
	input logic [frame_log_pkg::num_scripts-1:0] script_enable,

	output logic [data_width-1:0] log_data,
	output logic log_last,
	output logic log_valid,
	input logic log_ready
);
	logic data_push, data_pop, data_empty, data_full;
	logic [data_width-1:0] data_in, data_head;
	logic desc_push, desc_pop, desc_empty, desc_full;
	frame_log_pkg::desc_word_t desc_word, desc_head;
	logic first_beat;
	logic [frame_log_pkg::num_scripts-1:0] matched;
	logic frame_ready, desc_ready;

	assign data_pop = frame_ready & ~data_empty;
	assign desc_pop = desc_ready & ~desc_empty;

	frame_ingress #(.data_width(data_width)) ingress0 (
		.clk(clk), .rst_n(rst_n),
		.in_data(in_data), .in_bytes(in_bytes), .in_last(in_last),
		.in_valid(in_valid), .in_ready(in_ready),
		.data_full(data_full), .desc_full(desc_full), .matched(matched),
		.data_push(data_push), .data_out(data_in), .first_beat(first_beat),
		.desc_push(desc_push), .desc_out(desc_word)
	);

	script_match #(.data_width(data_width)) match0 (
		.clk(clk), .rst_n(rst_n),
		.beat(data_in), .first_beat(first_beat),
		.script_pattern(script_pattern), .script_mask(script_mask),
		.script_enable(script_enable), .matched(matched)
	);

	beat_fifo #(.width(data_width), .depth(data_depth)) data_fifo (
		.clk(clk), .rst_n(rst_n),
		.push(data_push), .din(data_in), .pop(data_pop),
		.dout(data_head), .empty(data_empty), .full(data_full)
	);

	beat_fifo #(.width(frame_log_pkg::desc_bits), .depth(desc_depth)) desc_fifo (
		.clk(clk), .rst_n(rst_n),
		.push(desc_push), .din(desc_word), .pop(desc_pop),
		.dout(desc_head), .empty(desc_empty), .full(desc_full)
	);

	frame_log_writer #(.data_width(data_width), .direction_id(direction_id)) writer0 (
		.clk(clk), .rst_n(rst_n), .log_id(log_id),
		.desc_in(desc_head), .desc_valid(~desc_empty), .desc_ready(desc_ready),
		.frame_data(data_head), .frame_valid(~data_empty), .frame_ready(frame_ready),
		.log_data(log_data), .log_last(log_last), .log_valid(log_valid),
		.log_ready(log_ready)
	);

endmodule

//--- logic/frame_log_writer.sv
/*
	Log writer
	Takes one descriptor per frame, emits the log header and the
	frame beats for matched frames, drains unmatched ones
*/

module frame_log_writer #(
	parameter int data_width = 64,
	parameter logic [7:0] direction_id = 8'd65
) (
	input logic clk,
	input logic rst_n,

	input logic [15:0] log_id,

	input frame_log_pkg::desc_word_t desc_in,
	input logic desc_valid,
	output logic desc_ready,

	input logic [data_width-1:0] frame_data,
	input logic frame_valid,
	output logic frame_ready,

	output logic [data_width-1:0] log_data,
	output logic log_last,
	output logic log_valid,
	input logic log_ready
);
	localparam int bpb = data_width / 8;
	localparam int hdr_beats = (frame_log_pkg::header_bits + data_width - 1) / data_width;
	localparam int buf_bits = hdr_beats * data_width;
	// Header bytes past the first 64 bits, in whole beats
	localparam int hdr_bytes = ((frame_log_pkg::header_bits + data_width - 65) / data_width) * bpb;
	localparam int cnt_bits = $clog2(hdr_beats + 1);

	localparam logic [1:0] st_wait = 2'd0;
	localparam logic [1:0] st_header = 2'd1;
	localparam logic [1:0] st_frame = 2'd2;
	localparam logic [1:0] st_drop = 2'd3;

	logic [1:0] state;
	logic [buf_bits-1:0] tx_buf;
	logic [buf_bits-1:0] hdr_word;
	logic [cnt_bits-1:0] tx_count;
	logic [15:0] remain;     // Frame bytes still to move
	logic [15:0] size_ceil;
	logic beat_end;
	logic hdr_end;

	assign size_ceil = (desc_in.f.size + 16'(bpb - 1)) & ~16'(bpb - 1);
	assign beat_end = (remain <= 16'(bpb));
	assign hdr_end = (tx_count == cnt_bits'(hdr_beats - 1));

	//------------------------------------------------------------
	// Header word
	//------------------------------------------------------------
	always_comb begin
		hdr_word = '0;
		hdr_word[31:0] = frame_log_pkg::log_magic;
		hdr_word[47:32] = log_id;
		hdr_word[63:48] = 16'(hdr_bytes) + size_ceil;
		hdr_word[127:64] = desc_in.f.timestamp;
		hdr_word[135:128] = direction_id;
		hdr_word[143:136] = 8'(bpb);
		hdr_word[159:144] = desc_in.f.size;
		hdr_word[160 +: frame_log_pkg::num_scripts] = desc_in.f.matched;
	end

	// Loaded while idle, shifted one beat per header transfer
	always_ff @(posedge clk) begin
		if (state == st_wait)
			tx_buf <= hdr_word;
		else if (state == st_header && log_ready)
			tx_buf <= tx_buf >> data_width;
	end

	//------------------------------------------------------------
	// FSM
	//------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= st_wait;
			desc_ready <= 1'b0;
			tx_count <= '0;
			remain <= '0;
		end else begin
			case (state)
				st_wait: begin
					desc_ready <= 1'b1;
					if (desc_valid && desc_ready) begin
						remain <= desc_in.f.size;
						tx_count <= '0;
						if (desc_in.f.matched != '0) begin
							state <= st_header;
							desc_ready <= 1'b0;
						end else if (desc_in.f.size != 16'd0) begin
							state <= st_drop;
							desc_ready <= 1'b0;
						end
					end
				end

				st_header: begin
					if (log_ready) begin
						if (hdr_end)
							state <= (remain != 16'd0) ? st_frame : st_wait;
						else
							tx_count <= tx_count + 1'b1;
					end
				end

				st_frame: begin
					if (frame_valid && log_ready) begin
						remain <= remain - 16'(bpb);
						if (beat_end)
							state <= st_wait;
					end
				end

				default: begin  // Drop, one beat per cycle
					if (frame_valid) begin
						remain <= remain - 16'(bpb);
						if (beat_end)
							state <= st_wait;
					end
				end
			endcase
		end
	end

	always_comb begin
		log_data = '0;
		log_last = 1'b0;
		log_valid = 1'b0;
		frame_ready = 1'b0;
		case (state)
			st_header: begin
				log_data = tx_buf[data_width-1:0];
				log_last = hdr_end && remain == 16'd0;
				log_valid = 1'b1;
			end
			st_frame: begin
				log_data = frame_data;
				log_last = beat_end;
				log_valid = frame_valid;
				frame_ready = log_ready;
			end
			st_drop: frame_ready = 1'b1;
			default: ;
		endcase
	end

	// Holds across the data FIFO head as well as the header buffer
	a_log_hold: assert property (@(posedge clk) disable iff (!rst_n)
		log_valid && !log_ready |=> log_valid && $stable(log_data) && $stable(log_last))
		else $error("log beat changed while stalled");

endmodule

//--- logic/script_match.sv
/*
	First-beat matcher
	Checks the opening beat of each frame against the scripts
*/

module script_match #(
	parameter int data_width = 64
) (
	input logic clk,
	input logic rst_n,

	input logic [data_width-1:0] beat,
	input logic first_beat,

	input logic [frame_log_pkg::num_scripts-1:0][data_width-1:0] script_pattern,
	input logic [frame_log_pkg::num_scripts-1:0][data_width-1:0] script_mask,
	input logic [frame_log_pkg::num_scripts-1:0] script_enable,

	output logic [frame_log_pkg::num_scripts-1:0] matched
);
	logic [frame_log_pkg::num_scripts-1:0] hit;

	// Mask bits select which beat bits must equal the pattern
	always_comb begin
		for (int i = 0; i < frame_log_pkg::num_scripts; i++) begin
			hit[i] = script_enable[i] &&
				((beat ^ script_pattern[i]) & script_mask[i]) == '0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			matched <= '0;
		end else if (first_beat) begin
			matched <= hit;  // Held for the rest of the frame
		end
	end

endmodule

//--- logic/frame_ingress.sv
/*
	Ingress stage of the frame logger
	Accepts beats, counts frame bytes, stamps the first beat
	and pushes one descriptor per frame
*/

module frame_ingress #(
	parameter int data_width = 64
) (
	input logic clk,
	input logic rst_n,

	input logic [data_width-1:0] in_data,
	input logic [$clog2(data_width/8):0] in_bytes,
	input logic in_last,
	input logic in_valid,
	output logic in_ready,

	input logic data_full,
	input logic desc_full,
	input logic [frame_log_pkg::num_scripts-1:0] matched,

	output logic data_push,
	output logic [data_width-1:0] data_out,
	output logic first_beat,
	output logic desc_push,
	output frame_log_pkg::desc_word_t desc_out
);
	localparam int bpb = data_width / 8;

	logic run;            // Low until the first cycle after reset
	logic first;          // Next accepted beat opens a frame
	logic [15:0] byte_cnt;
	logic [15:0] size_q;
	logic [63:0] ts_cnt;
	logic [63:0] ts_q;

	// A descriptor still in flight counts as occupying the FIFO
	assign in_ready = run & ~data_full & ~(in_last & (desc_full | desc_push));
	assign data_push = in_valid & in_ready;
	assign data_out = in_data;
	assign first_beat = data_push & first;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			run <= 1'b0;
			first <= 1'b1;
			byte_cnt <= '0;
			ts_cnt <= '0;
			desc_push <= 1'b0;
		end else begin
			run <= 1'b1;
			ts_cnt <= ts_cnt + 64'd1;
			desc_push <= data_push & in_last;

			if (data_push) begin
				if (in_last) begin
					first <= 1'b1;
					byte_cnt <= '0;
				end else begin
					first <= 1'b0;
					byte_cnt <= byte_cnt + 16'(bpb);  // Full beat
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (data_push && in_last)
			size_q <= byte_cnt + 16'(in_bytes);
		if (first_beat)
			ts_q <= ts_cnt;
	end

	// Matched bits settle one cycle after the first beat
	assign desc_out.raw = {matched, size_q, ts_q};

	a_last_bytes: assert property (@(posedge clk) disable iff (!rst_n)
		data_push && in_last |-> in_bytes >= 1 && in_bytes <= bpb)
		else $error("in_bytes %0d out of range on last beat", in_bytes);

endmodule

//--- logic/beat_fifo.sv
/*
	Synchronous FIFO, first word fall through
	Head word sits on dout whenever empty is low
*/

module beat_fifo #(
	parameter int width = 64,
	parameter int depth = 16
) (
	input logic clk,
	input logic rst_n,

	input logic push,
	input logic [width-1:0] din,
	input logic pop,

	output logic [width-1:0] dout,
	output logic empty,
	output logic full
);
	localparam int aw = $clog2(depth);

	logic [width-1:0] mem [depth];
	logic [aw-1:0] wr_ptr;
	logic [aw-1:0] rd_ptr;
	logic [aw:0] count;

	assign dout = mem[rd_ptr];
	assign empty = (count == '0);
	assign full = (count == (aw + 1)'(depth));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;

			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= din;
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) full |-> !push)
		else $error("push into full FIFO");
	a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) empty |-> !pop)
		else $error("pop from empty FIFO");

endmodule

//--- logic/frame_log_pkg.sv
/*
	Shared definitions for the frame logger
	Script count, log header constants and the descriptor word
*/

package frame_log_pkg;

	localparam int num_scripts = 4;

	// Log header buffer
	localparam logic [31:0] log_magic = 32'h02425AFF;
	localparam int header_bits = 176;

	// Descriptor is matched bits, size and timestamp
	localparam int desc_bits = num_scripts + 16 + 64;

	//------------------------------------------------------------
	// Descriptor word
	// Built as raw bits by the ingress stage and carried raw
	// through the FIFO, then decoded field by field in the writer
	//------------------------------------------------------------
	typedef union packed {
		logic [desc_bits-1:0] raw;
		struct packed {
			logic [num_scripts-1:0] matched;
			logic [15:0] size;       // Bytes
			logic [63:0] timestamp;  // Cycle count at first beat
		} f;
	} desc_word_t;

endpackage
